// File: include/proc_params.svh
//------------------------------------------------------------
// Sizing macros for the 16-bit single-cycle core
// Include wherever word width or memory depth is needed
//------------------------------------------------------------
`ifndef PROC_PARAMS_SVH
`define PROC_PARAMS_SVH

// Datapath word in bits
`define PROC_WORD_W 16

// Architectural register count
`define PROC_NREGS 8

// Memory depths in 16-bit words
`define PROC_IMEM_DEPTH 256
`define PROC_DMEM_DEPTH 256

`endif

// File: rtl/proc_pkg.sv
//------------------------------------------------------------
// Shared types for the single-cycle core
// Opcodes, instruction views, control and commit records
//------------------------------------------------------------
`default_nettype none
`include "proc_params.svh"

package proc_pkg;

   typedef enum logic [4:0] {
      OP_HALT  = 5'b00000,
      OP_NOP   = 5'b00001,
      OP_J     = 5'b00100,
      OP_JAL   = 5'b00110,
      OP_ADDI  = 5'b01000,
      OP_SUBI  = 5'b01001,
      OP_XORI  = 5'b01010,
      OP_ANDNI = 5'b01011,
      OP_BEQZ  = 5'b01100,
      OP_BNEZ  = 5'b01101,
      OP_ST    = 5'b10000,
      OP_LD    = 5'b10001,
      OP_SLBI  = 5'b10010,
      OP_LBI   = 5'b11000,
      OP_ALU_R = 5'b11011
   } opcode_e;

   // I-format; the 8-bit and 11-bit fields are its low bits
   typedef struct packed {
      opcode_e    opcode;
      logic [2:0] rs;
      logic [2:0] rd;
      logic [4:0] imm5;
   } instr_i_t;

   typedef struct packed {
      opcode_e    opcode;
      logic [2:0] rs;
      logic [2:0] rt;
      logic [2:0] rd;
      logic [1:0] func;
   } instr_r_t;

   typedef union packed {
      instr_i_t i;
      instr_r_t r;
   } instr_u;

   // Same order as the R-format func field
   typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_XOR, ALU_ANDN} alu_op_e;

   typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_IMM, WB_LINK} wb_sel_e;

   typedef struct packed {
      alu_op_e alu_op;
      logic    use_imm;
      logic    byte_shift;
      logic    reg_write;
      logic    mem_read;
      logic    mem_write;
      logic    is_branch;
      logic    branch_on_zero;
      logic    is_jump;
      logic    link;
      logic    halt;
      wb_sel_e wb_sel;
   } ctrl_t;

   typedef struct packed {
      logic                            valid;
      logic [$clog2(`PROC_NREGS)-1:0] rd;
      logic [`PROC_WORD_W-1:0]         data;
   } wb_t;

endpackage

`default_nettype wire

// File: rtl/fetch_unit.sv
//------------------------------------------------------------
// Program counter, loadable instruction memory, halt state
// The memory is filled through the load port while run is low
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "proc_params.svh"

module fetch_unit (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             run,
   input  logic             imem_we,
   input  logic [7:0]       imem_addr,
   input  logic [15:0]      imem_wdata,
   input  logic             halt_req,
   input  logic             pc_load,
   input  logic [15:0]      next_pc,
   output proc_pkg::instr_u instr,
   output logic [15:0]      pc_plus_two,
   output logic             halted,
   output logic             active
);
   import proc_pkg::*;

   localparam int IDX_W = $clog2(`PROC_IMEM_DEPTH);

   logic [`PROC_WORD_W-1:0] imem [`PROC_IMEM_DEPTH];
   logic [15:0]             pc;

   assign active      = run & ~halted;
   assign pc_plus_two = pc + 16'd2;

   // Byte PC, word-wide memory
   assign instr = instr_u'(imem[pc[IDX_W:1]]);

   always_ff @(posedge clk) begin
      if (imem_we && !run) begin
         imem[imem_addr] <= imem_wdata;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc     <= '0;
         halted <= 1'b0;
      end else if (active) begin
         // PC stays on the halt instruction
         if (halt_req) begin
            halted <= 1'b1;
         end else if (pc_load) begin
            pc <= next_pc;
         end else begin
            pc <= pc_plus_two;
         end
      end
   end

   a_pc_even: assert property (@(posedge clk) disable iff (!rst_n) pc[0] == 1'b0);

   // Program loading and execution never overlap
   a_load_idle: assert property (@(posedge clk) disable iff (!rst_n) !(imem_we && run));

endmodule

`default_nettype wire

// File: rtl/decode_unit.sv
//------------------------------------------------------------
// Instruction decode
// Produces control bits, register selects and the immediate
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
   input  proc_pkg::instr_u instr,
   output proc_pkg::ctrl_t  ctrl,
   output logic [2:0]       rs_sel,
   output logic [2:0]       rt_sel,
   output logic [2:0]       rd_sel,
   output logic [15:0]      imm,
   output logic             illegal
);
   import proc_pkg::*;

   logic [4:0]  opcode;
   logic [7:0]  imm8;
   logic [10:0] disp11;
   logic [15:0] imm5_sx;
   logic [15:0] imm5_zx;
   logic [15:0] imm8_sx;
   logic [15:0] imm8_zx;
   logic [15:0] disp11_sx;

   assign opcode    = instr.i.opcode;
   assign imm8      = instr.i[7:0];
   assign disp11    = instr.i[10:0];
   assign imm5_sx   = {{11{instr.i.imm5[4]}}, instr.i.imm5};
   assign imm5_zx   = {11'd0, instr.i.imm5};
   assign imm8_sx   = {{8{imm8[7]}}, imm8};
   assign imm8_zx   = {8'd0, imm8};
   assign disp11_sx = {{5{disp11[10]}}, disp11};

   assign rs_sel = instr.i.rs;
   // Also the store data register of the I-format
   assign rt_sel = instr.r.rt;

   always_comb begin
      ctrl    = '0;
      imm     = '0;
      illegal = 1'b0;
      case (opcode)
         OP_HALT: ctrl.halt = 1'b1;
         OP_NOP: ;
         OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI: begin
            // Low opcode bits follow the ALU op order
            ctrl.alu_op    = alu_op_e'(opcode[1:0]);
            ctrl.use_imm   = 1'b1;
            ctrl.reg_write = 1'b1;
            imm            = opcode[1] ? imm5_zx : imm5_sx;
         end
         OP_ALU_R: begin
            ctrl.alu_op    = alu_op_e'(instr.r.func);
            ctrl.reg_write = 1'b1;
         end
         OP_LD: begin
            ctrl.use_imm   = 1'b1;
            ctrl.mem_read  = 1'b1;
            ctrl.reg_write = 1'b1;
            ctrl.wb_sel    = WB_MEM;
            imm            = imm5_sx;
         end
         OP_ST: begin
            ctrl.use_imm   = 1'b1;
            ctrl.mem_write = 1'b1;
            imm            = imm5_sx;
         end
         OP_LBI: begin
            ctrl.reg_write = 1'b1;
            ctrl.wb_sel    = WB_IMM;
            imm            = imm8_sx;
         end
         OP_SLBI: begin
            ctrl.byte_shift = 1'b1;
            ctrl.reg_write  = 1'b1;
            imm             = imm8_zx;
         end
         OP_BEQZ, OP_BNEZ: begin
            ctrl.is_branch      = 1'b1;
            ctrl.branch_on_zero = (opcode == OP_BEQZ);
            imm                 = imm8_sx;
         end
         OP_J, OP_JAL: begin
            ctrl.is_jump = 1'b1;
            imm          = disp11_sx;
            if (opcode == OP_JAL) begin
               ctrl.link      = 1'b1;
               ctrl.reg_write = 1'b1;
               ctrl.wb_sel    = WB_LINK;
            end
         end
         default: illegal = 1'b1;
      endcase
   end

   always_comb begin
      if (ctrl.link) begin
         rd_sel = 3'd7;
      end else if (opcode == OP_ALU_R) begin
         rd_sel = instr.r.rd;
      end else if (opcode == OP_LBI || opcode == OP_SLBI) begin
         rd_sel = instr.i.rs;
      end else begin
         rd_sel = instr.i.rd;
      end
   end

endmodule

`default_nettype wire

// File: rtl/register_file.sv
//------------------------------------------------------------
// Eight-entry register file
// Two combinational read ports, one write port fed by commit
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "proc_params.svh"

module register_file (
   input  logic          clk,
   input  logic          rst_n,
   input  logic [2:0]    rs_sel,
   input  logic [2:0]    rt_sel,
   input  proc_pkg::wb_t wb,
   output logic [15:0]   rs_data,
   output logic [15:0]   rt_data
);

   logic [`PROC_WORD_W-1:0] regs [`PROC_NREGS];

   // No bypass since a write lands after the reading instruction is done
   assign rs_data = regs[rs_sel];
   assign rt_data = regs[rt_sel];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < `PROC_NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wb.valid) begin
         regs[wb.rd] <= wb.data;
      end
   end

endmodule

`default_nettype wire

// File: rtl/execute_unit.sv
//------------------------------------------------------------
// ALU, branch condition and next-PC selection
// Purely combinational, one instruction per cycle
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
   input  proc_pkg::ctrl_t ctrl,
   input  logic [15:0]     rs_data,
   input  logic [15:0]     rt_data,
   input  logic [15:0]     imm,
   input  logic [15:0]     pc_plus_two,
   output logic [15:0]     alu_result,
   output logic [15:0]     store_data,
   output logic [15:0]     next_pc,
   output logic            pc_load
);
   import proc_pkg::*;

   logic [15:0] op_b;
   logic [15:0] alu_out;
   logic [15:0] byte_merge;
   logic        rs_zero;
   logic        taken;

   assign op_b = ctrl.use_imm ? imm : rt_data;

   // Sums wrap at 16 bits
   always_comb begin
      case (ctrl.alu_op)
         ALU_ADD: alu_out = rs_data + op_b;
         ALU_SUB: alu_out = rs_data - op_b;
         ALU_XOR: alu_out = rs_data ^ op_b;
         default: alu_out = rs_data & ~op_b;
      endcase
   end

   // slbi keeps the low byte of rs as the new upper byte
   assign byte_merge = {rs_data[7:0], 8'h00} | imm;
   assign alu_result = ctrl.byte_shift ? byte_merge : alu_out;

   assign rs_zero = (rs_data == 16'h0000);
   assign taken   = ctrl.branch_on_zero ? rs_zero : ~rs_zero;

   // Branches and jumps share the PC-relative target
   assign next_pc = pc_plus_two + imm;
   assign pc_load = ctrl.is_jump | (ctrl.is_branch & taken);

   assign store_data = rt_data;

endmodule

`default_nettype wire

// File: rtl/memory_writeback.sv
//------------------------------------------------------------
// Data memory and writeback select
// Drives the commit record used by the register file and top
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "proc_params.svh"

module memory_writeback (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            active,
   input  logic            illegal,
   input  proc_pkg::ctrl_t ctrl,
   input  logic [2:0]      rd_sel,
   input  logic [15:0]     alu_result,
   input  logic [15:0]     store_data,
   input  logic [15:0]     imm,
   input  logic [15:0]     pc_plus_two,
   output proc_pkg::wb_t   wb
);
   import proc_pkg::*;

   localparam int IDX_W = $clog2(`PROC_DMEM_DEPTH);

   logic [`PROC_WORD_W-1:0] dmem [`PROC_DMEM_DEPTH];
   logic [IDX_W-1:0]        daddr;
   logic [15:0]             rdata;

   assign daddr = alu_result[IDX_W:1];
   assign rdata = ctrl.mem_read ? dmem[daddr] : '0;

   // Memory starts out all zero
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < `PROC_DMEM_DEPTH; i++) begin
            dmem[i] <= '0;
         end
      end else if (active && ctrl.mem_write) begin
         dmem[daddr] <= store_data;
      end
   end

   always_comb begin
      wb.valid = active & ctrl.reg_write & ~illegal;
      wb.rd    = rd_sel;
      case (ctrl.wb_sel)
         WB_MEM:  wb.data = rdata;
         WB_IMM:  wb.data = imm;
         WB_LINK: wb.data = pc_plus_two;
         default: wb.data = alu_result;
      endcase
   end

   a_one_store: assert property (
      @(posedge clk) disable iff (!rst_n)
      !(active && ctrl.mem_write && wb.valid)
   );

endmodule

`default_nettype wire

// File: rtl/proc.sv
//------------------------------------------------------------
// Top of the single-cycle core
// Load the program with run low, then raise run to execute
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module proc (
   input  logic          clk,
   input  logic          rst_n,
   input  logic          run,
   input  logic          imem_we,
   input  logic [7:0]    imem_addr,
   input  logic [15:0]   imem_wdata,
   output logic          halted,
   output proc_pkg::wb_t wb,
   output logic          err
);
   import proc_pkg::*;

   instr_u      instr;
   ctrl_t       ctrl;
   logic [2:0]  rs_sel;
   logic [2:0]  rt_sel;
   logic [2:0]  rd_sel;
   logic [15:0] imm;
   logic [15:0] rs_data;
   logic [15:0] rt_data;
   logic [15:0] pc_plus_two;
   logic [15:0] alu_result;
   logic [15:0] store_data;
   logic [15:0] next_pc;
   logic        pc_load;
   logic        active;
   logic        illegal;

   // Unknown opcodes only count while the core runs
   assign err = active & illegal;

   fetch_unit u_fetch (
      .clk        (clk),
      .rst_n      (rst_n),
      .run        (run),
      .imem_we    (imem_we),
      .imem_addr  (imem_addr),
      .imem_wdata (imem_wdata),
      .halt_req   (ctrl.halt),
      .pc_load    (pc_load),
      .next_pc    (next_pc),
      .instr      (instr),
      .pc_plus_two(pc_plus_two),
      .halted     (halted),
      .active     (active)
   );

   decode_unit u_decode (
      .instr  (instr),
      .ctrl   (ctrl),
      .rs_sel (rs_sel),
      .rt_sel (rt_sel),
      .rd_sel (rd_sel),
      .imm    (imm),
      .illegal(illegal)
   );

   register_file u_regs (
      .clk    (clk),
      .rst_n  (rst_n),
      .rs_sel (rs_sel),
      .rt_sel (rt_sel),
      .wb     (wb),
      .rs_data(rs_data),
      .rt_data(rt_data)
   );

   execute_unit u_exec (
      .ctrl       (ctrl),
      .rs_data    (rs_data),
      .rt_data    (rt_data),
      .imm        (imm),
      .pc_plus_two(pc_plus_two),
      .alu_result (alu_result),
      .store_data (store_data),
      .next_pc    (next_pc),
      .pc_load    (pc_load)
   );

   memory_writeback u_memwb (
      .clk        (clk),
      .rst_n      (rst_n),
      .active     (active),
      .illegal    (illegal),
      .ctrl       (ctrl),
      .rd_sel     (rd_sel),
      .alu_result (alu_result),
      .store_data (store_data),
      .imm        (imm),
      .pc_plus_two(pc_plus_two),
      .wb         (wb)
   );

endmodule

`default_nettype wire

// File: bench/proc_tb.sv
//------------------------------------------------------------
// Testbench for the single-cycle core
// Loads a program table, runs it and checks every commit,
// then checks halt behavior and an illegal opcode run
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "proc_params.svh"

module proc_tb;
   import proc_pkg::*;

   localparam int HALF_PERIOD = 10;
   localparam int DRIVE_SKEW  = 2;
   localparam int HOLD_CYCLES = 10;

   logic        clk;
   logic        rst_n;
   logic        run;
   logic        imem_we;
   logic [7:0]  imem_addr;
   logic [15:0] imem_wdata;
   logic        halted;
   wb_t         wb;
   logic        err;

   // Program table, one entry per instruction word in address order
   logic [15:0] prog_word [$];
   logic        exp_valid [$];
   logic [2:0]  exp_rd [$];
   logic [15:0] exp_data [$];
   logic        skipped [$];
   string       step_name [$];

   // Architectural register values the program should leave behind
   logic [15:0] model_regs [`PROC_NREGS];

   int checks;
   int value_errors;
   int status_errors;

   proc proc_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .run       (run),
      .imem_we   (imem_we),
      .imem_addr (imem_addr),
      .imem_wdata(imem_wdata),
      .halted    (halted),
      .wb        (wb),
      .err       (err)
   );

   initial begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   function automatic logic [15:0] sign5(input logic [4:0] v);
      return {{11{v[4]}}, v};
   endfunction

   function automatic logic [15:0] sign8(input logic [7:0] v);
      return {{8{v[7]}}, v};
   endfunction

   function automatic logic [15:0] i_word(input opcode_e op, input logic [2:0] rs,
                                          input logic [2:0] rd, input logic [4:0] imm5);
      return {op, rs, rd, imm5};
   endfunction

   function automatic logic [15:0] r_word(input logic [2:0] rs, input logic [2:0] rt,
                                          input logic [2:0] rd, input logic [1:0] func);
      return {OP_ALU_R, rs, rt, rd, func};
   endfunction

   function automatic logic [15:0] byte_word(input opcode_e op, input logic [2:0] rs,
                                             input logic [7:0] imm8);
      return {op, rs, imm8};
   endfunction

   function automatic logic [15:0] jump_word(input opcode_e op, input logic [10:0] disp);
      return {op, disp};
   endfunction

   task automatic push_entry(input logic [15:0] word, input logic valid, input logic [2:0] rd,
                             input logic [15:0] data, input logic skip, input string name);
      prog_word.push_back(word);
      exp_valid.push_back(valid);
      exp_rd.push_back(rd);
      exp_data.push_back(data);
      skipped.push_back(skip);
      step_name.push_back(name);
   endtask

   task automatic add_commit(input logic [15:0] word, input logic [2:0] rd,
                             input logic [15:0] data, input string name);
      push_entry(word, 1'b1, rd, data, 1'b0, name);
      model_regs[rd] = data;
   endtask

   // No register write; skip marks a word that control flow jumps over
   task automatic add_silent(input logic [15:0] word, input logic skip, input string name);
      push_entry(word, 1'b0, 3'd0, 16'h0000, skip, name);
   endtask

   task automatic build_program();
      logic [7:0] a;
      logic [7:0] b;
      logic [7:0] hi;
      logic [7:0] lo;
      logic [4:0] ia;
      logic [4:0] ib;
      logic [4:0] ic;
      logic [4:0] id;
      a  = 8'($urandom);
      b  = 8'($urandom);
      hi = 8'($urandom);
      lo = 8'($urandom);
      ia = 5'($urandom);
      ib = 5'($urandom);
      ic = 5'($urandom);
      id = 5'($urandom);
      for (int r = 0; r < `PROC_NREGS; r++) begin
         model_regs[r] = 16'h0000;
      end
      // ALU operations on random seeds
      add_commit(byte_word(OP_LBI, 3'd1, a), 3'd1, sign8(a), "lbi seed r1");
      add_commit(byte_word(OP_LBI, 3'd2, b), 3'd2, sign8(b), "lbi seed r2");
      add_commit(i_word(OP_ADDI, 3'd1, 3'd3, ia), 3'd3, model_regs[1] + sign5(ia), "addi");
      add_commit(i_word(OP_SUBI, 3'd2, 3'd4, ib), 3'd4, model_regs[2] - sign5(ib), "subi");
      add_commit(i_word(OP_XORI, 3'd1, 3'd5, ic), 3'd5, model_regs[1] ^ {11'd0, ic}, "xori");
      add_commit(i_word(OP_ANDNI, 3'd2, 3'd6, id), 3'd6, model_regs[2] & ~{11'd0, id},
                 "andni");
      add_commit(r_word(3'd1, 3'd2, 3'd3, 2'd0), 3'd3, model_regs[1] + model_regs[2], "add");
      add_commit(r_word(3'd1, 3'd2, 3'd4, 2'd1), 3'd4, model_regs[1] - model_regs[2], "sub");
      add_commit(r_word(3'd1, 3'd2, 3'd5, 2'd2), 3'd5, model_regs[1] ^ model_regs[2], "xor");
      add_commit(r_word(3'd1, 3'd2, 3'd6, 2'd3), 3'd6, model_regs[1] & ~model_regs[2], "andn");
      add_commit(byte_word(OP_LBI, 3'd1, 8'hFF), 3'd1, 16'hFFFF, "lbi minus one");
      add_commit(i_word(OP_ADDI, 3'd1, 3'd2, 5'd1), 3'd2, 16'h0000, "addi wrap");
      add_commit(i_word(OP_SUBI, 3'd2, 3'd3, 5'd1), 3'd3, 16'hFFFF, "subi wrap");
      // Byte loads
      add_commit(byte_word(OP_LBI, 3'd3, 8'h80), 3'd3, 16'hFF80, "lbi negative");
      add_commit(byte_word(OP_LBI, 3'd4, hi), 3'd4, sign8(hi), "lbi upper");
      add_commit(byte_word(OP_SLBI, 3'd4, lo), 3'd4, (model_regs[4] << 8) | {8'd0, lo},
                 "slbi");
      // Memory, base address 0x10 in r5
      add_commit(byte_word(OP_LBI, 3'd5, 8'h10), 3'd5, 16'h0010, "lbi base");
      add_silent(i_word(OP_ST, 3'd5, 3'd4, 5'd2), 1'b0, "st");
      add_commit(i_word(OP_LD, 3'd5, 3'd6, 5'd2), 3'd6, model_regs[4], "ld same address");
      add_commit(i_word(OP_LD, 3'd5, 3'd3, 5'd4), 3'd3, 16'h0000, "ld other address");
      // Control flow, r2 holds zero here
      add_silent(byte_word(OP_BEQZ, 3'd2, 8'd2), 1'b0, "beqz taken");
      add_silent(i_word(OP_ADDI, 3'd1, 3'd1, 5'd1), 1'b1, "addi after beqz");
      add_commit(i_word(OP_ADDI, 3'd0, 3'd3, 5'd5), 3'd3, model_regs[0] + 16'd5,
                 "beqz target");
      add_silent(byte_word(OP_BNEZ, 3'd2, 8'd2), 1'b0, "bnez not taken");
      add_commit(i_word(OP_ADDI, 3'd3, 3'd4, 5'd1), 3'd4, model_regs[3] + 16'd1,
                 "bnez fall through");
      // Link is the byte address after the jal
      add_commit(jump_word(OP_JAL, 11'd0), 3'd7, 16'(prog_word.size() * 2 + 2), "jal");
      add_silent(jump_word(OP_J, 11'd2), 1'b0, "j forward");
      add_silent(i_word(OP_ADDI, 3'd1, 3'd1, 5'd1), 1'b1, "addi after j");
      add_commit(i_word(OP_ADDI, 3'd7, 3'd5, 5'd0), 3'd5, model_regs[7], "link value");
      add_silent(16'h0000, 1'b0, "halt");
   endtask

   task automatic apply_reset();
      rst_n = 1'b0;
      run   = 1'b0;
      repeat (8) @(posedge clk);
      #DRIVE_SKEW;
      rst_n = 1'b1;
   endtask

   task automatic write_imem(input logic [7:0] addr, input logic [15:0] data);
      imem_we    = 1'b1;
      imem_addr  = addr;
      imem_wdata = data;
      @(posedge clk);
      #DRIVE_SKEW;
      imem_we = 1'b0;
   endtask

   task automatic load_program();
      for (int k = 0; k < prog_word.size(); k++) begin
         write_imem(8'(k), prog_word[k]);
      end
   endtask

   task automatic check_commit(input int k);
      checks++;
      assert (wb.valid == exp_valid[k]) else begin
         value_errors++;
         $display("error %s valid expected %0b actual %0b", step_name[k], exp_valid[k],
                  wb.valid);
      end
      if (exp_valid[k]) begin
         assert (wb.rd == exp_rd[k]) else begin
            value_errors++;
            $display("error %s reg expected %0d actual %0d", step_name[k], exp_rd[k], wb.rd);
         end
         assert (wb.data == exp_data[k]) else begin
            value_errors++;
            $display("error %s data expected %h actual %h", step_name[k], exp_data[k],
                     wb.data);
         end
      end
      assert (!err && !halted) else begin
         status_errors++;
         $display("At %s the core showed err or halted while running a legal program",
                  step_name[k]);
      end
   endtask

   task automatic report_counts();
      $display("checks %0d, value errors %0d, status errors %0d", checks, value_errors,
               status_errors);
   endtask

   initial begin : watchdog
      int unsigned limit_cycles;
      #1;
      // Table is loaded and run once, plus resets, halt hold and the error run
      limit_cycles = 2 * prog_word.size() + 60;
      repeat (limit_cycles) @(posedge clk);
      $display("Timeout, the run did not finish within %0d cycles", limit_cycles);
      report_counts();
      $display("SIMULATION FAILED");
      $finish;
   end

   initial begin
      rst_n      = 1'b0;
      run        = 1'b0;
      imem_we    = 1'b0;
      imem_addr  = 8'd0;
      imem_wdata = 16'h0000;
      checks        = 0;
      value_errors  = 0;
      status_errors = 0;
      void'($urandom(46126));
      build_program();
      apply_reset();
      load_program();
      run = 1'b1;
      // One instruction per cycle, skipped words never reach commit
      for (int k = 0; k < prog_word.size(); k++) begin
         if (!skipped[k]) begin
            @(negedge clk);
            check_commit(k);
         end
      end
      repeat (HOLD_CYCLES) begin
         @(negedge clk);
         checks++;
         assert (halted && !wb.valid && !err) else begin
            status_errors++;
            $display("Core did not stay halted and silent after the halt instruction");
         end
      end
      // Second run with an unassigned opcode at address 0
      @(posedge clk);
      #DRIVE_SKEW;
      apply_reset();
      write_imem(8'd0, 16'hF800);
      write_imem(8'd1, 16'h0000);
      run = 1'b1;
      @(negedge clk);
      checks++;
      assert (err == 1'b1) else begin
         value_errors++;
         $display("error illegal opcode err expected 1 actual %0b", err);
      end
      assert (!wb.valid) else begin
         value_errors++;
         $display("error illegal opcode valid expected 0 actual %0b", wb.valid);
      end
      @(negedge clk);
      checks++;
      assert (!err && !halted) else begin
         status_errors++;
         $display("Halt after the illegal opcode saw err or an early halted level");
      end
      @(negedge clk);
      checks++;
      assert (halted) else begin
         status_errors++;
         $display("Core did not halt after the illegal opcode run");
      end
      report_counts();
      if (value_errors == 0 && status_errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: proc.f
+incdir+include
rtl/proc_pkg.sv
rtl/fetch_unit.sv
rtl/decode_unit.sv
rtl/register_file.sv
rtl/execute_unit.sv
rtl/memory_writeback.sv
rtl/proc.sv
bench/proc_tb.sv

// File: Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall
TOP        := proc_tb
DUT_TOP    := proc
FILELIST   := proc.f
BUILD_DIR  := obj_dir
LOG        := sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST)) include/proc_params.svh

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
